//--- common/fpgaIpPkg.sv
// FPGA IP shared definitions
// Bus width, register offsets, target map and reset constants
// used by the register block, the RAM target and the address decoder

package fpgaIpPkg;

    // ------------------------------
    // Bus
    // ------------------------------

    // Host data bus width, four byte strobes
    localparam int DataWidth = 32;

    // Widest GPIO the register block supports
    localparam int MaxGpioWidth = 24;

    // ------------------------------
    // Register map
    // ------------------------------

    // Word offsets inside the register block
    typedef enum logic [7:0] {
        DEVICE_ID = 8'd0,
        CLK_CNTL  = 8'd1,
        GPIO_IN   = 8'd2,
        GPIO_OUT  = 8'd3,
        GPIO_OE   = 8'd4,
        SCRATCH   = 8'd5
    } regOffsetE;

    // Targets selected by the two top address bits
    // Code 2'b11 also decodes to TGT_NONE
    typedef enum logic [1:0] {
        TGT_REGS = 2'd0,
        TGT_RAM  = 2'd1,
        TGT_NONE = 2'd2
    } targetE;

    // ------------------------------
    // Constants
    // ------------------------------

    // Read-only device identifier
    localparam logic [23:0] DeviceId = 24'h55C332;

    // Returned for any address nobody claims
    localparam logic [DataWidth-1:0] DefaultRead = 32'hFABDEFAC;

    // Both clock enables on out of reset
    localparam logic [1:0] ClkCntlReset = 2'b11;

    // Scratch power-on pattern
    localparam logic [DataWidth-1:0] ScratchReset = 32'h12345678;

    // GPIO driven low and tristated out of reset
    localparam logic [MaxGpioWidth-1:0] GpioOutReset = '0;
    localparam logic [MaxGpioWidth-1:0] GpioOeReset  = '0;

endpackage

//--- flist.f
+incdir+verif
common/fpgaIpPkg.sv
fpgaRegisters/fpgaRegisters.sv
fpgaRam/fpgaRam.sv
verilog/wbAddrDecode.sv
verilog/fpgaIp.sv
verif/fpgaIpTb.sv

//--- fpgaRam/fpgaRam.sv
// FPGA RAM target
// Word-addressed single-port RAM with byte-lane writes
// Read word registered on the accept edge, one-cycle acknowledge

`timescale 1ns/1ps

module fpgaRam #(
    parameter int BlkAddrWidth = 8
) (
    input  logic                               WBs_CLK_i,
    input  logic                               WBs_RST_i,

    // Bus slave side
    input  logic [BlkAddrWidth-1:0]            ramAdr_i,
    input  logic                               ramCyc_i,
    input  logic                               ramStb_i,
    input  logic                               ramWe_i,
    input  logic [3:0]                         ramByteStb_i,
    input  logic [fpgaIpPkg::DataWidth-1:0]    ramDat_i,
    output logic [fpgaIpPkg::DataWidth-1:0]    ramDat_o,
    output logic                               ramAck_o
);

    localparam int Depth = 2 ** BlkAddrWidth;

    // Storage, contents undefined after power-up
    logic [fpgaIpPkg::DataWidth-1:0] mem [0:Depth-1];

    // First cycle of a request, before ack
    logic                            accept;

    assign accept = ramCyc_i & ramStb_i & ~ramAck_o;

    // ------------------------------
    // Array access
    // ------------------------------

    always_ff @(posedge WBs_CLK_i)
    begin
        if (accept)
        begin
            if (ramWe_i)
            begin
                // Only strobed lanes are written
                for (int lane = 0; lane < fpgaIpPkg::DataWidth / 8; lane++)
                begin
                    if (ramByteStb_i[lane])
                    begin
                        mem[ramAdr_i][8*lane +: 8] <= ramDat_i[8*lane +: 8];
                    end
                end
            end
            else
            begin
                // Read word lands with the ack
                ramDat_o <= mem[ramAdr_i];
            end
        end
    end

    // ------------------------------
    // Acknowledge
    // ------------------------------

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            ramAck_o <= 1'b0;
        end
        else
        begin
            ramAck_o <= accept;
        end
    end

endmodule

//--- fpgaRegisters/fpgaRegisters.sv
// FPGA register block
// Device ID, clock-enable control, GPIO out/OE/in and scratch registers
// Byte-masked writes, combinational reads, one-cycle acknowledge
// GPIO inputs pass a two-stage synchronizer before they can be read

`timescale 1ns/1ps

module fpgaRegisters #(
    parameter int BlkAddrWidth = 8,
    parameter int GpioWidth    = 23
) (
    input  logic                               WBs_CLK_i,
    input  logic                               WBs_RST_i,

    // Bus slave side
    input  logic [BlkAddrWidth-1:0]            regAdr_i,
    input  logic                               regCyc_i,
    input  logic                               regStb_i,
    input  logic                               regWe_i,
    input  logic [3:0]                         regByteStb_i,
    input  logic [fpgaIpPkg::DataWidth-1:0]    regDat_i,
    output logic [fpgaIpPkg::DataWidth-1:0]    regDat_o,
    output logic                               regAck_o,

    // Pins and misc
    input  logic [GpioWidth-1:0]               gpioIn_i,
    output logic [GpioWidth-1:0]               gpioOut_o,
    output logic [GpioWidth-1:0]               gpioOe_o,
    output logic                               clk4mCntl_o,
    output logic                               clk1mCntl_o,
    output logic [23:0]                        deviceId_o
);

    // Write enable for the whole block
    logic                             wrEn;

    // Per-register write decodes
    logic                             wrClkCntl;
    logic                             wrGpioOut;
    logic                             wrGpioOe;
    logic                             wrScratch;

    // Register storage
    logic [1:0]                       clkCntl;
    logic [fpgaIpPkg::DataWidth-1:0]  scratchReg;

    // Two-flop GPIO input synchronizer
    logic [GpioWidth-1:0]             gpioInMeta;
    logic [GpioWidth-1:0]             gpioInSync;

    // ------------------------------
    // Write decode
    // ------------------------------

    // Only the first cycle of a request writes, ack blocks the repeat
    assign wrEn = regCyc_i & regStb_i & regWe_i & ~regAck_o;

    assign wrClkCntl = wrEn & (regAdr_i == BlkAddrWidth'(fpgaIpPkg::CLK_CNTL));
    assign wrGpioOut = wrEn & (regAdr_i == BlkAddrWidth'(fpgaIpPkg::GPIO_OUT));
    assign wrGpioOe  = wrEn & (regAdr_i == BlkAddrWidth'(fpgaIpPkg::GPIO_OE));
    assign wrScratch = wrEn & (regAdr_i == BlkAddrWidth'(fpgaIpPkg::SCRATCH));

    // ------------------------------
    // Registers and acknowledge
    // ------------------------------

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            clkCntl    <= fpgaIpPkg::ClkCntlReset;
            gpioOut_o  <= fpgaIpPkg::GpioOutReset[GpioWidth-1:0];
            gpioOe_o   <= fpgaIpPkg::GpioOeReset[GpioWidth-1:0];
            scratchReg <= fpgaIpPkg::ScratchReset;
            regAck_o   <= 1'b0;
        end
        else
        begin
            // Clock enables live in lane 0
            if (wrClkCntl && regByteStb_i[0])
            begin
                clkCntl <= regDat_i[1:0];
            end

            // GPIO bits follow the strobe of their byte lane
            for (int bitIdx = 0; bitIdx < GpioWidth; bitIdx++)
            begin
                if (wrGpioOut && regByteStb_i[bitIdx / 8])
                begin
                    gpioOut_o[bitIdx] <= regDat_i[bitIdx];
                end
                if (wrGpioOe && regByteStb_i[bitIdx / 8])
                begin
                    gpioOe_o[bitIdx] <= regDat_i[bitIdx];
                end
            end

            // Scratch, full 32 bits by lane
            for (int lane = 0; lane < fpgaIpPkg::DataWidth / 8; lane++)
            begin
                if (wrScratch && regByteStb_i[lane])
                begin
                    scratchReg[8*lane +: 8] <= regDat_i[8*lane +: 8];
                end
            end

            // One-cycle ack, drops for a cycle even if STB stays high
            regAck_o <= regCyc_i & regStb_i & ~regAck_o;
        end
    end

    // GPIO input synchronizer
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            gpioInMeta <= '0;
            gpioInSync <= '0;
        end
        else
        begin
            gpioInMeta <= gpioIn_i;
            gpioInSync <= gpioInMeta;
        end
    end

    // ------------------------------
    // Read mux and outputs
    // ------------------------------

    // Zero-extended, valid while address is held
    always_comb
    begin
        case (regAdr_i)
            BlkAddrWidth'(fpgaIpPkg::DEVICE_ID): regDat_o = fpgaIpPkg::DataWidth'(deviceId_o);
            BlkAddrWidth'(fpgaIpPkg::CLK_CNTL):  regDat_o = fpgaIpPkg::DataWidth'(clkCntl);
            BlkAddrWidth'(fpgaIpPkg::GPIO_IN):   regDat_o = fpgaIpPkg::DataWidth'(gpioInSync);
            BlkAddrWidth'(fpgaIpPkg::GPIO_OUT):  regDat_o = fpgaIpPkg::DataWidth'(gpioOut_o);
            BlkAddrWidth'(fpgaIpPkg::GPIO_OE):   regDat_o = fpgaIpPkg::DataWidth'(gpioOe_o);
            BlkAddrWidth'(fpgaIpPkg::SCRATCH):   regDat_o = scratchReg;
            default:                             regDat_o = fpgaIpPkg::DefaultRead;
        endcase
    end

    // Bit 0 gates the 4 MHz clock, bit 1 the 1 MHz clock
    assign clk4mCntl_o = clkCntl[0];
    assign clk1mCntl_o = clkCntl[1];

    assign deviceId_o = fpgaIpPkg::DeviceId;

endmodule

//--- verif/fpgaIpRef.svh
// FPGA IP testbench reference model
// Shadow copies of the register block and RAM, byte-lane write rules,
// expected read word for any address and the LFSR stimulus source

`ifndef FPGA_IP_REF_SVH
`define FPGA_IP_REF_SVH

// Fibonacci LFSR state, taps 32 22 2 1
logic [31:0]          lfsrState = 32'h09b6_47e0;

// Register shadows, GPIO words kept masked to GpioWidth
logic [1:0]           shadowClkCntl = fpgaIpPkg::ClkCntlReset;
logic [DataWidth-1:0] shadowGpioOut = '0;
logic [DataWidth-1:0] shadowGpioOe  = '0;
logic [DataWidth-1:0] shadowScratch = fpgaIpPkg::ScratchReset;

// Value driven on the GPIO input pins
logic [DataWidth-1:0] shadowGpioIn  = '0;

// RAM shadow, only written words are ever read
logic [DataWidth-1:0] shadowRam [0:RamDepth-1];

// Next count bits of the LFSR, one step per bit
function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        value     = {value[30:0], feedback};
    end
    return value;
endfunction

// Replace the strobed byte lanes of a word
function automatic logic [DataWidth-1:0] mergeLanes(input logic [DataWidth-1:0] oldWord,
                                                    input logic [DataWidth-1:0] newWord,
                                                    input logic [3:0]           strb);
    logic [DataWidth-1:0] merged;
    merged = oldWord;
    for (int lane = 0; lane < 4; lane++)
    begin
        if (strb[lane])
        begin
            merged[8*lane +: 8] = newWord[8*lane +: 8];
        end
    end
    return merged;
endfunction

// Apply one host write to the shadow state
function automatic void shadowWrite(input logic [AddrWidth-1:0] addr,
                                    input logic [DataWidth-1:0] data,
                                    input logic [3:0]           strb);
    logic [BlkAddrWidth-1:0] offset;
    offset = addr[BlkAddrWidth-1:0];
    if (addr[AddrWidth-1 -: 2] == 2'b01)
    begin
        shadowRam[offset] = mergeLanes(shadowRam[offset], data, strb);
    end
    else if (addr[AddrWidth-1 -: 2] == 2'b00)
    begin
        // ID, GPIO_IN and holes ignore writes
        case (offset)
            fpgaIpPkg::CLK_CNTL: shadowClkCntl = strb[0] ? data[1:0] : shadowClkCntl;
            fpgaIpPkg::GPIO_OUT: shadowGpioOut = mergeLanes(shadowGpioOut, data, strb) & GpioMask;
            fpgaIpPkg::GPIO_OE:  shadowGpioOe  = mergeLanes(shadowGpioOe, data, strb) & GpioMask;
            fpgaIpPkg::SCRATCH:  shadowScratch = mergeLanes(shadowScratch, data, strb);
            default:             ;
        endcase
    end
endfunction

// Expected read word, zero-extended, default word for holes
function automatic logic [DataWidth-1:0] refRead(input logic [AddrWidth-1:0] addr);
    logic [BlkAddrWidth-1:0] offset;
    offset = addr[BlkAddrWidth-1:0];
    if (addr[AddrWidth-1 -: 2] == 2'b01)
    begin
        return shadowRam[offset];
    end
    if (addr[AddrWidth-1 -: 2] != 2'b00)
    begin
        return fpgaIpPkg::DefaultRead;
    end
    case (offset)
        fpgaIpPkg::DEVICE_ID: return {8'h00, fpgaIpPkg::DeviceId};
        fpgaIpPkg::CLK_CNTL:  return {30'd0, shadowClkCntl};
        fpgaIpPkg::GPIO_IN:   return shadowGpioIn;
        fpgaIpPkg::GPIO_OUT:  return shadowGpioOut;
        fpgaIpPkg::GPIO_OE:   return shadowGpioOe;
        fpgaIpPkg::SCRATCH:   return shadowScratch;
        default:              return fpgaIpPkg::DefaultRead;
    endcase
endfunction

`endif

//--- verif/fpgaIpTb.sv
// FPGA IP testbench
// Drives the host bus through register, GPIO, RAM and unmapped accesses
// Read data is checked against the reference model at each acknowledge

`timescale 1ns/1ps

module fpgaIpTb;

    localparam int AddrWidth    = 10;
    localparam int GpioWidth    = 23;
    localparam int BlkAddrWidth = AddrWidth - 2;
    localparam int DataWidth    = fpgaIpPkg::DataWidth;
    localparam int RamDepth     = 2 ** BlkAddrWidth;
    localparam logic [DataWidth-1:0] GpioMask = (32'd1 << GpioWidth) - 1;
    localparam int ClkPeriod    = 20;

    // Test lengths
    localparam int NumRegWrites = 18;
    localparam int NumGpioIn    = 5;
    localparam int NumRamWords  = 12;

    // Bus cycles, GPIO settle waits counted as one each
    localparam int NumTransactions = 6 + 2 * NumRegWrites + 10 + 2 * NumGpioIn + 4
                                     + 4 * NumRamWords + 20;
    localparam int WatchdogCycles  = NumTransactions * 4 + 8 + 50;

    logic                    WBs_CLK_i = 1'b0;
    logic                    WBs_RST_i;
    logic [AddrWidth-1:0]    wbsAdr_i;
    logic                    wbsCyc_i;
    logic                    wbsStb_i;
    logic                    wbsWe_i;
    logic [3:0]              wbsByteStb_i;
    logic [DataWidth-1:0]    wbsDat_i;
    logic [DataWidth-1:0]    wbsDat_o;
    logic                    wbsAck_o;
    logic [GpioWidth-1:0]    gpioIn_i;
    logic [GpioWidth-1:0]    gpioOut_o;
    logic [GpioWidth-1:0]    gpioOe_o;
    logic                    clk4mCntl_o;
    logic                    clk1mCntl_o;
    logic [23:0]             deviceId_o;

    // Expected words of outstanding reads
    logic [DataWidth-1:0]    expectQ[$];
    logic [AddrWidth-1:0]    expectAdrQ[$];
    logic [DataWidth-1:0]    readExp;
    logic [AddrWidth-1:0]    readAdr;
    logic [AddrWidth-1:0]    ramAddrs [0:NumRamWords-1];
    int                      errorCount = 0;

    `include "fpgaIpRef.svh"

    fpgaIp fpgaIp_i (
        .WBs_CLK_i    (WBs_CLK_i),
        .WBs_RST_i    (WBs_RST_i),
        .wbsAdr_i     (wbsAdr_i),
        .wbsCyc_i     (wbsCyc_i),
        .wbsStb_i     (wbsStb_i),
        .wbsWe_i      (wbsWe_i),
        .wbsByteStb_i (wbsByteStb_i),
        .wbsDat_i     (wbsDat_i),
        .wbsDat_o     (wbsDat_o),
        .wbsAck_o     (wbsAck_o),
        .gpioIn_i     (gpioIn_i),
        .gpioOut_o    (gpioOut_o),
        .gpioOe_o     (gpioOe_o),
        .clk4mCntl_o  (clk4mCntl_o),
        .clk1mCntl_o  (clk1mCntl_o),
        .deviceId_o   (deviceId_o)
    );

    always #(ClkPeriod / 2) WBs_CLK_i = ~WBs_CLK_i;

    // ------------------------------
    // Error handling and compares
    // ------------------------------

    task automatic failNow(input string line);
        errorCount++;
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic checkWord(input logic [DataWidth-1:0] actual,
                             input logic [DataWidth-1:0] expected, input string what);
        if (actual !== expected)
        begin
            failNow($sformatf("[FAIL] %0t ns: %s got %h expected %h",
                              $time, what, actual, expected));
        end
    endtask

    task automatic checkGpio(input logic [GpioWidth-1:0] actual,
                             input logic [GpioWidth-1:0] expected, input string what);
        if (actual !== expected)
        begin
            failNow($sformatf("[FAIL] %0t ns: %s got %h expected %h",
                              $time, what, actual, expected));
        end
    endtask

    task automatic checkBit(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            failNow($sformatf("[FAIL] %0t ns: %s got %b expected %b",
                              $time, what, actual, expected));
        end
    endtask

    // Read data compared at every read acknowledge
    always @(negedge WBs_CLK_i)
    begin
        if (!WBs_RST_i && wbsAck_o && wbsCyc_i && !wbsWe_i)
        begin
            if (expectQ.size() == 0)
            begin
                failNow("A read was acknowledged with no read outstanding");
            end
            else
            begin
                readExp = expectQ.pop_front();
                readAdr = expectAdrQ.pop_front();
                checkWord(wbsDat_o, readExp, $sformatf("read at %h", readAdr));
            end
        end
    end

    // ------------------------------
    // Bus tasks
    // ------------------------------

    // ACK must show up exactly one edge after the request
    task automatic waitAck(input logic [AddrWidth-1:0] addr);
        int edges;
        edges = 0;
        @(negedge WBs_CLK_i);
        while (wbsAck_o !== 1'b1)
        begin
            @(negedge WBs_CLK_i);
            edges++;
        end
        if (edges != 1)
        begin
            failNow($sformatf("ACK for address %h came %0d edges after the request, not 1",
                              addr, edges));
        end
        @(posedge WBs_CLK_i);
        wbsCyc_i <= 1'b0;
        wbsStb_i <= 1'b0;
    endtask

    task automatic busWrite(input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] data, input logic [3:0] strb);
        shadowWrite(addr, data, strb);
        @(posedge WBs_CLK_i);
        wbsAdr_i     <= addr;
        wbsDat_i     <= data;
        wbsByteStb_i <= strb;
        wbsWe_i      <= 1'b1;
        wbsCyc_i     <= 1'b1;
        wbsStb_i     <= 1'b1;
        waitAck(addr);
    endtask

    task automatic busRead(input logic [AddrWidth-1:0] addr);
        expectQ.push_back(refRead(addr));
        expectAdrQ.push_back(addr);
        @(posedge WBs_CLK_i);
        wbsAdr_i     <= addr;
        wbsByteStb_i <= 4'hF;
        wbsWe_i      <= 1'b0;
        wbsCyc_i     <= 1'b1;
        wbsStb_i     <= 1'b1;
        waitAck(addr);
    endtask

    function automatic logic [AddrWidth-1:0] regAddr(input logic [BlkAddrWidth-1:0] offset);
        return {2'b00, offset};
    endfunction

    // Pin outputs against the shadow registers
    task automatic checkPins();
        @(negedge WBs_CLK_i);
        checkGpio(gpioOut_o, shadowGpioOut[GpioWidth-1:0], "gpioOut_o");
        checkGpio(gpioOe_o, shadowGpioOe[GpioWidth-1:0], "gpioOe_o");
        checkBit(clk4mCntl_o, shadowClkCntl[0], "clk4mCntl_o");
        checkBit(clk1mCntl_o, shadowClkCntl[1], "clk1mCntl_o");
        checkWord({8'h00, deviceId_o}, {8'h00, fpgaIpPkg::DeviceId}, "deviceId_o");
    endtask

    // New pin value, then three edges for the synchronizer
    task automatic setGpioIn(input logic [DataWidth-1:0] value);
        shadowGpioIn = value & GpioMask;
        @(posedge WBs_CLK_i);
        gpioIn_i <= shadowGpioIn[GpioWidth-1:0];
        repeat (3) @(posedge WBs_CLK_i);
    endtask

    task automatic readAllRegs();
        for (int off = 0; off < 6; off++)
        begin
            busRead(regAddr(off));
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    initial
    begin
        WBs_RST_i    = 1'b1;
        wbsAdr_i     = '0;
        wbsCyc_i     = 1'b0;
        wbsStb_i     = 1'b0;
        wbsWe_i      = 1'b0;
        wbsByteStb_i = '0;
        wbsDat_i     = '0;
        gpioIn_i     = '0;
        repeat (8) @(posedge WBs_CLK_i);
        WBs_RST_i <= 1'b0;

        // Reset values
        readAllRegs();
        checkPins();

        // Byte-strobed GPIO_OUT, GPIO_OE and SCRATCH writes
        for (int i = 0; i < NumRegWrites; i++)
        begin
            readAdr = regAddr(8'(3 + randBits(2) % 3));
            busWrite(readAdr, randBits(32), randBits(4));
            busRead(readAdr);
            checkPins();
        end

        // Clock enables follow lane 0 only
        busWrite(regAddr(fpgaIpPkg::CLK_CNTL), 32'h0, 4'b0001);
        checkPins();
        busWrite(regAddr(fpgaIpPkg::CLK_CNTL), 32'h3, 4'b1110);
        checkPins();
        busWrite(regAddr(fpgaIpPkg::CLK_CNTL), 32'h2, 4'b1111);
        checkPins();
        busWrite(regAddr(fpgaIpPkg::CLK_CNTL), 32'h1, 4'b0010);
        checkPins();
        busWrite(regAddr(fpgaIpPkg::CLK_CNTL), 32'h1, 4'b0001);
        busRead(regAddr(fpgaIpPkg::CLK_CNTL));
        checkPins();

        // GPIO input through the synchronizer, read-only registers
        for (int i = 0; i < NumGpioIn; i++)
        begin
            setGpioIn(randBits(32));
            busRead(regAddr(fpgaIpPkg::GPIO_IN));
        end
        busWrite(regAddr(fpgaIpPkg::GPIO_IN), randBits(32), 4'hF);
        busWrite(regAddr(fpgaIpPkg::DEVICE_ID), randBits(32), 4'hF);
        busRead(regAddr(fpgaIpPkg::GPIO_IN));
        busRead(regAddr(fpgaIpPkg::DEVICE_ID));

        // RAM, full word first so no lane stays unknown
        for (int i = 0; i < NumRamWords; i++)
        begin
            ramAddrs[i] = {2'b01, 8'(randBits(8))};
            busWrite(ramAddrs[i], randBits(32), 4'hF);
            busWrite(ramAddrs[i], randBits(32), randBits(4));
        end
        for (int i = NumRamWords - 1; i >= 0; i--)
        begin
            busRead(ramAddrs[i]);
        end

        // Unmapped offsets and both empty ranges
        for (int i = 0; i < 4; i++)
        begin
            busRead(regAddr(8'(6 + randBits(8) % 250)));
            busRead({2'b10 + 2'(i % 2), 8'(randBits(8))});
        end
        busWrite(regAddr(8'(6 + randBits(8) % 250)), randBits(32), 4'hF);
        busWrite(regAddr(8'(6 + randBits(8) % 250)), randBits(32), 4'hF);
        busWrite({2'b10, fpgaIpPkg::SCRATCH}, randBits(32), 4'hF);
        busWrite({2'b10, ramAddrs[0][7:0]}, randBits(32), 4'hF);
        busWrite({2'b11, fpgaIpPkg::GPIO_OUT}, randBits(32), 4'hF);
        busWrite({2'b11, ramAddrs[1][7:0]}, randBits(32), 4'hF);
        readAllRegs();
        for (int i = 0; i < NumRamWords; i++)
        begin
            busRead(ramAddrs[i]);
        end
        checkPins();

        @(negedge WBs_CLK_i);
        if (errorCount == 0 && expectQ.size() == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the planned transaction count
    initial
    begin
        #(WatchdogCycles * ClkPeriod);
        failNow("Watchdog expired, a bus cycle was never acknowledged or the run stalled");
    end

endmodule

//--- verilog/fpgaIp.sv
// FPGA IP top level
// Host Wishbone slave port behind one address decoder
// Targets are the register block and the byte-enabled RAM
// GPIO, clock-enable and device ID pins come from the register block

`timescale 1ns/1ps

module fpgaIp #(
    parameter int AddrWidth = 10,
    parameter int GpioWidth = 23
) (
    input  logic                               WBs_CLK_i,
    input  logic                               WBs_RST_i,

    // Host bus
    input  logic [AddrWidth-1:0]               wbsAdr_i,
    input  logic                               wbsCyc_i,
    input  logic                               wbsStb_i,
    input  logic                               wbsWe_i,
    input  logic [3:0]                         wbsByteStb_i,
    input  logic [fpgaIpPkg::DataWidth-1:0]    wbsDat_i,
    output logic [fpgaIpPkg::DataWidth-1:0]    wbsDat_o,
    output logic                               wbsAck_o,

    // Pins
    input  logic [GpioWidth-1:0]               gpioIn_i,
    output logic [GpioWidth-1:0]               gpioOut_o,
    output logic [GpioWidth-1:0]               gpioOe_o,
    output logic                               clk4mCntl_o,
    output logic                               clk1mCntl_o,
    output logic [23:0]                        deviceId_o
);

    // Two top bits go to the decoder
    localparam int BlkAddrWidth = AddrWidth - 2;

    // Decoder to target wiring
    logic                            regStb;
    logic                            ramStb;
    logic [fpgaIpPkg::DataWidth-1:0] regDat;
    logic                            regAck;
    logic [fpgaIpPkg::DataWidth-1:0] ramDat;
    logic                            ramAck;

    // ------------------------------
    // Address decoder
    // ------------------------------

    wbAddrDecode #(
        .AddrWidth (AddrWidth)
    ) wbAddrDecode_i (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .wbsAdr_i  (wbsAdr_i),
        .wbsCyc_i  (wbsCyc_i),
        .wbsStb_i  (wbsStb_i),
        .wbsDat_o  (wbsDat_o),
        .wbsAck_o  (wbsAck_o),
        .regStb_o  (regStb),
        .ramStb_o  (ramStb),
        .regDat_i  (regDat),
        .regAck_i  (regAck),
        .ramDat_i  (ramDat),
        .ramAck_i  (ramAck)
    );

    // ------------------------------
    // Targets
    // ------------------------------

    fpgaRegisters #(
        .BlkAddrWidth (BlkAddrWidth),
        .GpioWidth    (GpioWidth)
    ) fpgaRegisters_i (
        .WBs_CLK_i    (WBs_CLK_i),
        .WBs_RST_i    (WBs_RST_i),
        .regAdr_i     (wbsAdr_i[BlkAddrWidth-1:0]),
        .regCyc_i     (wbsCyc_i),
        .regStb_i     (regStb),
        .regWe_i      (wbsWe_i),
        .regByteStb_i (wbsByteStb_i),
        .regDat_i     (wbsDat_i),
        .regDat_o     (regDat),
        .regAck_o     (regAck),
        .gpioIn_i     (gpioIn_i),
        .gpioOut_o    (gpioOut_o),
        .gpioOe_o     (gpioOe_o),
        .clk4mCntl_o  (clk4mCntl_o),
        .clk1mCntl_o  (clk1mCntl_o),
        .deviceId_o   (deviceId_o)
    );

    fpgaRam #(
        .BlkAddrWidth (BlkAddrWidth)
    ) fpgaRam_i (
        .WBs_CLK_i    (WBs_CLK_i),
        .WBs_RST_i    (WBs_RST_i),
        .ramAdr_i     (wbsAdr_i[BlkAddrWidth-1:0]),
        .ramCyc_i     (wbsCyc_i),
        .ramStb_i     (ramStb),
        .ramWe_i      (wbsWe_i),
        .ramByteStb_i (wbsByteStb_i),
        .ramDat_i     (wbsDat_i),
        .ramDat_o     (ramDat),
        .ramAck_o     (ramAck)
    );

endmodule

//--- verilog/wbAddrDecode.sv
// Wishbone address decoder
// Picks the target from the two top address bits and gates STB to it
// Returns the selected target's read data and ack to the host
// Unmapped space gets its own one-cycle ack and the default word

`timescale 1ns/1ps

module wbAddrDecode #(
    parameter int AddrWidth = 10
) (
    input  logic                               WBs_CLK_i,
    input  logic                               WBs_RST_i,

    // Host side
    input  logic [AddrWidth-1:0]               wbsAdr_i,
    input  logic                               wbsCyc_i,
    input  logic                               wbsStb_i,
    output logic [fpgaIpPkg::DataWidth-1:0]    wbsDat_o,
    output logic                               wbsAck_o,

    // Target strobes
    output logic                               regStb_o,
    output logic                               ramStb_o,

    // Target responses
    input  logic [fpgaIpPkg::DataWidth-1:0]    regDat_i,
    input  logic                               regAck_i,
    input  logic [fpgaIpPkg::DataWidth-1:0]    ramDat_i,
    input  logic                               ramAck_i
);

    fpgaIpPkg::targetE target;

    // Request toward unmapped space
    logic              noneStb;

    // Ack for unmapped cycles
    logic              noneAck;

    // ------------------------------
    // Target select
    // ------------------------------

    // 00 registers, 01 RAM, 1x nothing
    always_comb
    begin
        case (wbsAdr_i[AddrWidth-1 -: 2])
            2'b00:   target = fpgaIpPkg::TGT_REGS;
            2'b01:   target = fpgaIpPkg::TGT_RAM;
            default: target = fpgaIpPkg::TGT_NONE;
        endcase
    end

    assign regStb_o = wbsStb_i & (target == fpgaIpPkg::TGT_REGS);
    assign ramStb_o = wbsStb_i & (target == fpgaIpPkg::TGT_RAM);
    assign noneStb  = wbsCyc_i & wbsStb_i & (target == fpgaIpPkg::TGT_NONE);

    // ------------------------------
    // Unmapped responder
    // ------------------------------

    // Writes here just get acked and dropped
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            noneAck <= 1'b0;
        end
        else
        begin
            noneAck <= noneStb & ~noneAck;
        end
    end

    // ------------------------------
    // Response merge
    // ------------------------------

    always_comb
    begin
        case (target)
            fpgaIpPkg::TGT_REGS:
            begin
                wbsDat_o = regDat_i;
                wbsAck_o = regAck_i;
            end
            fpgaIpPkg::TGT_RAM:
            begin
                wbsDat_o = ramDat_i;
                wbsAck_o = ramAck_i;
            end
            default:
            begin
                wbsDat_o = fpgaIpPkg::DefaultRead;
                wbsAck_o = noneAck;
            end
        endcase
    end

endmodule
